// File: rtl/mips_mem_pkg.sv
`default_nettype none

package mips_mem_pkg;

	// size constants for the memory stage.
	localparam int data_w      = 32; // width of one data word.
	localparam int reg_addr_w  = 5;  // width of a register file index.
	localparam int mem_words   = 64; // depth of the data memory in words.
	localparam int word_addr_w = 6;  // width of a memory word index.
	localparam int byte_lanes  = 4;  // byte lanes in one data word.

	// plain word and index types.
	typedef logic [data_w-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [word_addr_w-1:0] word_addr_t;

	// bit 0 enables the least significant byte of the word.
	typedef logic [byte_lanes-1:0] byte_en_t;

	// memory control as it comes out of decode.
	// with size_half and size_byte both clear the access is a full word.
	typedef struct packed {
		logic mem_write;   // store into the data memory.
		logic mem_read;    // load from the data memory.
		logic branch;      // beq or bne in this slot.
		logic branch_ne;   // set for bne, clear for beq.
		logic is_unsigned; // zero extension on partial loads.
		logic size_half;   // halfword access.
		logic size_byte;   // byte access.
	} mem_ctrl_t;

	// write-back control carried through the pipeline register.
	typedef struct packed {
		logic reg_write;  // the destination register gets written.
		logic mem_to_reg; // write-back takes read_data instead of the address.
	} wb_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/dmem_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dmem_if;

	mips_mem_pkg::word_addr_t addr;    // word index of the access.
	mips_mem_pkg::byte_en_t   byte_en; // lanes written when write is high.
	logic                     write;   // single cycle write strobe.
	mips_mem_pkg::word_t      wdata;   // lane replicated store data.
	mips_mem_pkg::word_t      rdata;   // word at addr, always valid.

	// the side that issues the access.
	modport master
	(
		output addr,
		output byte_en,
		output write,
		output wdata,
		input  rdata
	);

	// the memory side.
	modport slave
	(
		input  addr,
		input  byte_en,
		input  write,
		input  wdata,
		output rdata
	);

endinterface

`default_nettype wire

// File: rtl/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem
(
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire mips_mem_pkg::word_addr_t debug_addr,
	dmem_if.slave                         bus,
	output mips_mem_pkg::word_t           debug_data
);

	mips_mem_pkg::word_t mem [mips_mem_pkg::mem_words]; // contents survive reset.

	// lanes are written one by one so partial stores leave the rest alone.
	always_ff @(posedge clk)
	begin
		if (!reset && bus.write) // no write is taken while reset is held.
		begin
			for (int i = 0; i < mips_mem_pkg::byte_lanes; i++)
			begin
				if (bus.byte_en[i])
				begin
					mem[bus.addr][i*8 +: 8] <= bus.wdata[i*8 +: 8];
				end
			end
		end
	end

	// both read ports are asynchronous.
	assign bus.rdata  = mem[bus.addr];
	assign debug_data = mem[debug_addr]; // used by the debug unit.

endmodule

`default_nettype wire

// File: rtl/mem_access.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access
(
	input  wire logic                    advance,
	input  wire mips_mem_pkg::word_t     alu_result,
	input  wire mips_mem_pkg::word_t     store_data,
	input  wire mips_mem_pkg::mem_ctrl_t mem_ctrl,
	input  wire logic                    zero,
	input  wire mips_mem_pkg::word_t     pc_branch_in,
	output logic                         pc_src,
	output mips_mem_pkg::word_t          pc_branch,
	output mips_mem_pkg::word_t          load_data,
	dmem_if.master                       bus
);

	logic [1:0]              lane;     // byte offset inside the word.
	logic [15:0]             half_sel; // halfword picked by address bit 1.
	logic [7:0]              byte_sel; // byte picked by the byte offset.
	mips_mem_pkg::byte_en_t  st_en;
	mips_mem_pkg::word_t     st_data;

	assign lane = alu_result[1:0];

	// bits 7 to 2 of the byte address give the word index.
	assign bus.addr = alu_result[mips_mem_pkg::word_addr_w+1:2];

	// stores only happen in a cycle where the pipeline moves.
	assign bus.write = mem_ctrl.mem_write & advance;

	// the data is replicated into every lane and byte_en picks the ones that land.
	always_comb
	begin
		st_en   = '1;
		st_data = store_data;
		if (mem_ctrl.size_half)
		begin
			st_data = {2{store_data[15:0]}};
			st_en   = lane[1] ? 4'b1100 : 4'b0011;
		end
		else if (mem_ctrl.size_byte)
		begin
			st_data = {4{store_data[7:0]}};
			st_en   = mips_mem_pkg::byte_en_t'(1) << lane;
		end
	end

	assign bus.byte_en = st_en;
	assign bus.wdata   = st_data;

	// lane extraction on the returned word.
	assign half_sel = lane[1] ? bus.rdata[31:16] : bus.rdata[15:0];
	assign byte_sel = bus.rdata[lane*8 +: 8];

	// shift the selected lanes down and extend them to a full word.
	always_comb
	begin
		load_data = bus.rdata; // anything but a partial load passes the raw word.
		if (mem_ctrl.mem_read)
		begin
			if (mem_ctrl.size_half)
			begin
				if (mem_ctrl.is_unsigned)
					load_data = {16'h0000, half_sel};
				else
					load_data = {{16{half_sel[15]}}, half_sel};
			end
			else if (mem_ctrl.size_byte)
			begin
				if (mem_ctrl.is_unsigned)
					load_data = {24'h000000, byte_sel};
				else
					load_data = {{24{byte_sel[7]}}, byte_sel};
			end
		end
	end

	// beq takes the branch on zero, bne on not zero.
	assign pc_src    = mem_ctrl.branch & (mem_ctrl.branch_ne ? ~zero : zero);
	assign pc_branch = pc_branch_in; // the target was computed in execute.

endmodule

`default_nettype wire

// File: rtl/mem_wb_reg.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_reg
(
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire logic                     advance,
	input  wire mips_mem_pkg::word_t      load_data,
	input  wire mips_mem_pkg::word_t      alu_result,
	input  wire mips_mem_pkg::wb_ctrl_t   wb_ctrl_in,
	input  wire mips_mem_pkg::reg_addr_t  write_reg_in,
	input  wire logic                     halt_in,
	output mips_mem_pkg::word_t           read_data,
	output mips_mem_pkg::word_t           addr_out,
	output mips_mem_pkg::wb_ctrl_t        wb_ctrl_out,
	output mips_mem_pkg::reg_addr_t       write_reg_out,
	output logic                          halt_out
);

	// all fields move together so write-back sees one consistent item.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			read_data     <= '0;
			addr_out      <= '0;
			wb_ctrl_out   <= '0; // no register write after reset.
			write_reg_out <= '0;
			halt_out      <= 1'b0;
		end
		else if (advance)
		begin
			read_data     <= load_data;
			addr_out      <= alu_result; // write-back result of non-load instructions.
			wb_ctrl_out   <= wb_ctrl_in;
			write_reg_out <= write_reg_in;
			halt_out      <= halt_in;
		end
		// with advance low every field keeps its value.
	end

endmodule

`default_nettype wire

// File: rtl/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage
(
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire logic                     advance,
	input  wire mips_mem_pkg::word_t      alu_result,
	input  wire mips_mem_pkg::word_t      store_data,
	input  wire mips_mem_pkg::word_t      pc_branch_in,
	input  wire mips_mem_pkg::mem_ctrl_t  mem_ctrl,
	input  wire mips_mem_pkg::wb_ctrl_t   wb_ctrl_in,
	input  wire mips_mem_pkg::reg_addr_t  write_reg_in,
	input  wire logic                     zero,
	input  wire logic                     halt_in,
	input  wire mips_mem_pkg::word_addr_t debug_addr,
	output logic                          pc_src,
	output mips_mem_pkg::word_t           pc_branch,
	output mips_mem_pkg::word_t           read_data,
	output mips_mem_pkg::word_t           addr_out,
	output mips_mem_pkg::wb_ctrl_t        wb_ctrl_out,
	output mips_mem_pkg::reg_addr_t       write_reg_out,
	output logic                          halt_out,
	output mips_mem_pkg::word_t           debug_data
);

	mips_mem_pkg::word_t load_data; // extended load result before the register.

	dmem_if dmem_bus ();

	// address, lanes, extension and the branch decision.
	mem_access u_mem_access
	(
		.advance      (advance),
		.alu_result   (alu_result),
		.store_data   (store_data),
		.mem_ctrl     (mem_ctrl),
		.zero         (zero),
		.pc_branch_in (pc_branch_in),
		.pc_src       (pc_src),
		.pc_branch    (pc_branch),
		.load_data    (load_data),
		.bus          (dmem_bus.master)
	);

	data_mem u_data_mem
	(
		.clk        (clk),
		.reset      (reset),
		.debug_addr (debug_addr),
		.bus        (dmem_bus.slave),
		.debug_data (debug_data)
	);

	// memory to write-back latch.
	mem_wb_reg u_mem_wb_reg
	(
		.clk           (clk),
		.reset         (reset),
		.advance       (advance),
		.load_data     (load_data),
		.alu_result    (alu_result),
		.wb_ctrl_in    (wb_ctrl_in),
		.write_reg_in  (write_reg_in),
		.halt_in       (halt_in),
		.read_data     (read_data),
		.addr_out      (addr_out),
		.wb_ctrl_out   (wb_ctrl_out),
		.write_reg_out (write_reg_out),
		.halt_out      (halt_out)
	);

endmodule

`default_nettype wire

// File: dv/tb_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;

	localparam int reset_cycles = 10;
	localparam int n_fill       = 64; // one word store per memory word.
	localparam int n_word_ld    = 40;
	localparam int n_part_st    = 60;
	localparam int n_check_ld   = 32; // word loads that confirm the memory contents.
	localparam int n_part_ld    = 80; // each one is a store followed by a partial load.
	localparam int n_branch     = 40;
	localparam int n_stall      = 40;
	localparam int max_stretch  = 4;  // longest run of cycles with advance low.
	localparam int planned_cycles = n_fill + n_word_ld + n_part_st + 2 * n_check_ld
		+ 2 * n_part_ld + n_branch + n_stall * (max_stretch + 1) + 4;
	localparam int cycle_limit  = 2 * planned_cycles + reset_cycles;

	// what the write-back register should hold after one advance edge.
	typedef struct packed {
		mips_mem_pkg::word_t     data;
		logic                    data_valid; // read_data is only known for loads of written words.
		mips_mem_pkg::word_t     addr;
		mips_mem_pkg::wb_ctrl_t  wb;
		mips_mem_pkg::reg_addr_t reg_idx;
		logic                    halt;
	} wb_expect_t;

	logic                     clk;
	logic                     reset;
	logic                     advance;
	mips_mem_pkg::word_t      alu_result;
	mips_mem_pkg::word_t      store_data;
	mips_mem_pkg::word_t      pc_branch_in;
	mips_mem_pkg::mem_ctrl_t  mem_ctrl;
	mips_mem_pkg::wb_ctrl_t   wb_ctrl_in;
	mips_mem_pkg::reg_addr_t  write_reg_in;
	logic                     zero;
	logic                     halt_in;
	mips_mem_pkg::word_addr_t debug_addr;
	logic                     pc_src;
	mips_mem_pkg::word_t      pc_branch;
	mips_mem_pkg::word_t      read_data;
	mips_mem_pkg::word_t      addr_out;
	mips_mem_pkg::wb_ctrl_t   wb_ctrl_out;
	mips_mem_pkg::reg_addr_t  write_reg_out;
	logic                     halt_out;
	mips_mem_pkg::word_t      debug_data;

	mips_mem_pkg::word_t shadow [mips_mem_pkg::mem_words]; // expected memory contents.
	logic                written [mips_mem_pkg::mem_words]; // words with known contents.
	wb_expect_t          expect_q [$];
	logic                exp_pc_src;
	mips_mem_pkg::word_t exp_pc_branch;
	mips_mem_pkg::word_t exp_debug;
	logic                debug_valid;

	mem_stage UUT
	(
		.clk           (clk),
		.reset         (reset),
		.advance       (advance),
		.alu_result    (alu_result),
		.store_data    (store_data),
		.pc_branch_in  (pc_branch_in),
		.mem_ctrl      (mem_ctrl),
		.wb_ctrl_in    (wb_ctrl_in),
		.write_reg_in  (write_reg_in),
		.zero          (zero),
		.halt_in       (halt_in),
		.debug_addr    (debug_addr),
		.pc_src        (pc_src),
		.pc_branch     (pc_branch),
		.read_data     (read_data),
		.addr_out      (addr_out),
		.wb_ctrl_out   (wb_ctrl_out),
		.write_reg_out (write_reg_out),
		.halt_out      (halt_out),
		.debug_data    (debug_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period.
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic word_check(input string name, input mips_mem_pkg::word_t exp,
		input mips_mem_pkg::word_t act);
		if (act !== exp)
			stop_run($sformatf("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act));
	endtask

	task automatic reg_index_check(input string name, input mips_mem_pkg::reg_addr_t exp,
		input mips_mem_pkg::reg_addr_t act);
		if (act !== exp)
			stop_run($sformatf("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act));
	endtask

	task automatic wb_ctrl_check(input string name, input mips_mem_pkg::wb_ctrl_t exp,
		input mips_mem_pkg::wb_ctrl_t act);
		if (act !== exp)
			stop_run($sformatf("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act));
	endtask

	task automatic bit_check(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act));
	endtask

	// the word left in memory after a store, built lane by lane.
	function automatic mips_mem_pkg::word_t merge_store(input mips_mem_pkg::word_t old_word,
		input mips_mem_pkg::word_t data, input mips_mem_pkg::mem_ctrl_t ctrl,
		input logic [1:0] offset);
		mips_mem_pkg::word_t result;
		logic [7:0]          src;
		logic                hit;
		result = old_word;
		for (int i = 0; i < mips_mem_pkg::byte_lanes; i++)
		begin
			if (ctrl.size_half)
			begin
				hit = ((i / 2) == int'(offset[1])); // the half chosen by address bit 1.
				src = data[(i % 2) * 8 +: 8];
			end
			else if (ctrl.size_byte)
			begin
				hit = (i == int'(offset));
				src = data[7:0];
			end
			else
			begin
				hit = 1'b1;
				src = data[i * 8 +: 8];
			end
			if (hit)
				result[i * 8 +: 8] = src;
		end
		return result;
	endfunction

	// the value a load returns from a stored word.
	function automatic mips_mem_pkg::word_t extend_load(input mips_mem_pkg::word_t w,
		input mips_mem_pkg::mem_ctrl_t ctrl, input logic [1:0] offset);
		mips_mem_pkg::word_t result;
		logic [15:0]         half;
		logic [7:0]          lane_byte;
		result = w;
		if (ctrl.size_half)
		begin
			half = 16'(w >> (16 * int'(offset[1])));
			result = ctrl.is_unsigned ? {16'h0000, half} : {{16{half[15]}}, half};
		end
		else if (ctrl.size_byte)
		begin
			lane_byte = 8'(w >> (8 * int'(offset)));
			result = ctrl.is_unsigned ? {24'h000000, lane_byte} : {{24{lane_byte[7]}}, lane_byte};
		end
		return result;
	endfunction

	function automatic logic branch_taken(input mips_mem_pkg::mem_ctrl_t ctrl, input logic z);
		if (!ctrl.branch)
			return 1'b0;
		if (ctrl.branch_ne)
			return !z; // bne.
		return z;
	endfunction

	function automatic mips_mem_pkg::mem_ctrl_t make_ctrl(input logic wr, input logic rd,
		input logic half, input logic byt, input logic uns);
		mips_mem_pkg::mem_ctrl_t ctrl;
		ctrl = '0;
		ctrl.mem_write   = wr;
		ctrl.mem_read    = rd;
		ctrl.size_half   = half;
		ctrl.size_byte   = byt;
		ctrl.is_unsigned = uns;
		return ctrl;
	endfunction

	// drives one item 1 ns after the edge and records what it should produce.
	task automatic issue_item(input logic adv, input mips_mem_pkg::mem_ctrl_t ctrl_in,
		input mips_mem_pkg::word_addr_t index, input logic [1:0] offset,
		input mips_mem_pkg::word_t data);
		mips_mem_pkg::mem_ctrl_t ctrl;
		wb_expect_t              item;
		ctrl = ctrl_in;
		ctrl.branch    = 1'($urandom);
		ctrl.branch_ne = 1'($urandom);
		@(posedge clk);
		#1;
		advance      = adv;
		alu_result   = {24'($urandom), index, offset}; // upper bits are outside the memory.
		store_data   = data;
		mem_ctrl     = ctrl;
		wb_ctrl_in   = 2'($urandom);
		write_reg_in = 5'($urandom);
		zero         = 1'($urandom);
		halt_in      = 1'($urandom);
		pc_branch_in = $urandom;
		debug_addr   = 6'($urandom);
		exp_pc_src    = branch_taken(ctrl, zero);
		exp_pc_branch = pc_branch_in;
		exp_debug     = shadow[debug_addr];
		debug_valid   = written[debug_addr];
		if (adv)
		begin
			item.data       = extend_load(shadow[index], ctrl, offset);
			item.data_valid = ctrl.mem_read && written[index];
			item.addr       = alu_result;
			item.wb         = wb_ctrl_in;
			item.reg_idx    = write_reg_in;
			item.halt       = halt_in;
			expect_q.push_back(item);
			if (ctrl.mem_write)
			begin
				shadow[index] = merge_store(shadow[index], data, ctrl, offset);
				if (!ctrl.size_half && !ctrl.size_byte)
					written[index] = 1'b1;
			end
		end
	endtask

	// registered outputs are checked half a cycle after each edge, when they are settled.
	initial
	begin : compare_outputs
		wb_expect_t exp_now;
		logic       adv_seen;
		exp_now = '0;
		exp_now.data_valid = 1'b1; // read_data is zero after reset.
		@(negedge reset);
		forever
		begin
			@(posedge clk);
			adv_seen = advance;
			@(negedge clk);
			if (adv_seen)
			begin
				if (expect_q.size() == 0)
					stop_run("the DUT advanced but no item was waiting to be checked");
				exp_now = expect_q.pop_front();
			end
			if (exp_now.data_valid)
				word_check("read_data", exp_now.data, read_data);
			word_check("addr_out", exp_now.addr, addr_out);
			wb_ctrl_check("wb_ctrl_out", exp_now.wb, wb_ctrl_out);
			reg_index_check("write_reg_out", exp_now.reg_idx, write_reg_out);
			bit_check("halt_out", exp_now.halt, halt_out);
			bit_check("pc_src", exp_pc_src, pc_src);
			word_check("pc_branch", exp_pc_branch, pc_branch);
			if (debug_valid)
				word_check("debug_data", exp_debug, debug_data);
		end
	end

	initial
	begin : watchdog
		repeat (cycle_limit) @(posedge clk);
		stop_run($sformatf("timeout: the run did not end within %0d clock cycles", cycle_limit));
	end

	initial
	begin : main_sequence
		mips_mem_pkg::word_t data;
		logic [1:0]          sz;
		logic                half;
		int                  stretch;
		void'($urandom(32'hbef08d61));
		reset         = 1'b1;
		advance       = 1'b0;
		alu_result    = '0;
		store_data    = '0;
		pc_branch_in  = '0;
		mem_ctrl      = '0;
		wb_ctrl_in    = '0;
		write_reg_in  = '0;
		zero          = 1'b0;
		halt_in       = 1'b0;
		debug_addr    = '0;
		exp_pc_src    = 1'b0;
		exp_pc_branch = '0;
		exp_debug     = '0;
		debug_valid   = 1'b0;
		for (int i = 0; i < mips_mem_pkg::mem_words; i++)
			written[i] = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		word_check("read_data", '0, read_data);
		word_check("addr_out", '0, addr_out);
		reg_index_check("write_reg_out", '0, write_reg_out);
		wb_ctrl_check("wb_ctrl_out", '0, wb_ctrl_out);
		bit_check("halt_out", 1'b0, halt_out);
		@(posedge clk);
		#1 reset = 1'b0;

		for (int i = 0; i < n_fill; i++)
			issue_item(1'b1, make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 6'(i), 2'($urandom), $urandom);
		for (int i = 0; i < n_word_ld; i++)
			issue_item(1'b1, make_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), 6'($urandom), 2'($urandom),
				$urandom);

		for (int i = 0; i < n_part_st; i++)
		begin
			half = 1'($urandom);
			issue_item(1'b1, make_ctrl(1'b1, 1'b0, half, !half, 1'b0), 6'($urandom), 2'($urandom),
				$urandom);
		end
		for (int i = 0; i < n_check_ld; i++)
			issue_item(1'b1, make_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), 6'($urandom), 2'($urandom),
				$urandom);

		// sign bits of every lane alternate between set and clear.
		for (int i = 0; i < n_part_ld; i++)
		begin
			data = (i % 2 == 0) ? ($urandom | 32'h80808080) : ($urandom & 32'h7f7f7f7f);
			sz   = 2'($urandom); // byte offset, which a word store ignores.
			half = 1'($urandom);
			issue_item(1'b1, make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 6'(i), sz, data);
			issue_item(1'b1, make_ctrl(1'b0, 1'b1, half, !half, 1'($urandom)), 6'(i), 2'($urandom),
				$urandom);
		end

		for (int i = 0; i < n_branch; i++)
			issue_item(1'b1, make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0), 6'($urandom), 2'($urandom),
				$urandom);

		// stores issued while stalled must not reach the memory.
		for (int i = 0; i < n_stall; i++)
		begin
			stretch = 1 + int'($urandom % max_stretch);
			repeat (stretch)
			begin
				sz = 2'($urandom % 3);
				issue_item(1'b0, make_ctrl(1'b1, 1'b0, sz == 2'd1, sz == 2'd2, 1'b0), 6'($urandom),
					2'($urandom), $urandom);
			end
			issue_item(1'b1, make_ctrl(i % 2 == 0, i % 2 == 1, 1'b0, 1'b0, 1'b0), 6'($urandom),
				2'($urandom), $urandom);
		end
		for (int i = 0; i < n_check_ld; i++)
			issue_item(1'b1, make_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), 6'($urandom), 2'($urandom),
				$urandom);

		issue_item(1'b0, make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0), '0, 2'b00, '0);
		repeat (2) @(negedge clk);
		if (expect_q.size() != 0)
			stop_run("some items were never registered by the DUT");
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
rtl/mips_mem_pkg.sv
rtl/dmem_if.sv
rtl/data_mem.sv
rtl/mem_access.sv
rtl/mem_wb_reg.sv
rtl/mem_stage.sv
dv/tb_mem_stage.sv

// File: run.sh
#!/bin/sh
# Builds the memory stage testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module tb_mem_stage \
	-f build.f --Mdir obj_dir -o tb_mem_stage
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

output=$(./obj_dir/tb_mem_stage 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1
